/* rv_core.f */
hdl/rv_pkg.sv
hdl/pipe_control.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_core.sv
bench/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_rv_core \
    -f rv_core.f -Mdir obj_dir -o sim_rv_core; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_rv_core)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qxF "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  // rv32i opcodes for the encoders
  localparam logic [6:0] op_r      = 7'b0110011;
  localparam logic [6:0] op_i      = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  // a store here ends a program
  localparam logic [31:0] marker_addr = 32'h0000_03fc;
  localparam int timeout_cycles = 1000;

  // op index order is add sub and or xor slt sll srl
  localparam logic [2:0] f3_table [8] = '{3'b000, 3'b000, 3'b111, 3'b110,
                                          3'b100, 3'b010, 3'b001, 3'b101};
  localparam int i_ops [5] = '{0, 2, 3, 4, 5};

  logic clk = 1'b0;
  logic arst_n;
  logic [31:0] imem_addr, imem_data, dmem_addr, dmem_wdata;
  logic [31:0] dmem_rdata = '0;
  logic [31:0] rd_word = '0;
  logic dmem_we;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  int prog_len;

  string test_name;
  int test_errs, tests_run, tests_failed, total_errs;

  rv_core rv_core_i (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_we_o    (dmem_we),
    .dmem_rdata_i (dmem_rdata)
  );

  always #10 clk = ~clk;

  // ====================
  // memory models
  // ====================
  assign imem_data = imem[imem_addr[9:2]];

  // read before write with the data handed over on the falling edge
  always @(posedge clk) begin
    rd_word <= dmem[dmem_addr[9:2]];
    if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  always @(negedge clk) begin
    dmem_rdata <= rd_word;
  end

  function automatic logic [31:0] fill_of(input logic [31:0] addr);
    return ~addr ^ {addr[15:0], addr[31:16]};
  endfunction

  // ====================
  // instruction encoders
  // ====================
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_r};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], op_store};
  endfunction

  function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [11:0] off);
    return enc_i(off, 5'd0, 3'b010, rd, op_load);
  endfunction

  // expected results straight from the rv32i definitions
  function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return {31'd0, $signed(a) < $signed(b)};
      6:       return a << b[4:0];
      7:       return a >> b[4:0];
      default: return a + b;
    endcase
  endfunction

  // ====================
  // program and run helpers
  // ====================
  task automatic put(input logic [31:0] instr);
    imem[8'(prog_len)] = instr;
    prog_len++;
  endtask

  // lui then addi with the upper part rounded for the sign of the low twelve bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h0000_0800;
    put({upper[31:12], rd, op_lui});
    put(enc_i(value[11:0], rd, 3'b000, rd, op_i));
  endtask

  task automatic start_program();
    @(negedge clk);
    arst_n = 1'b0;
    prog_len = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, op_i);
      dmem[i] = fill_of(32'(i) << 2);
    end
  endtask

  task automatic release_reset();
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
  endtask

  // ends with the marker store and a jump to itself
  task automatic run_program();
    bit seen;
    seen = 1'b0;
    put(store_word(5'd0, marker_addr[11:0]));
    put(enc_j(21'd0, 5'd0));
    release_reset();
    for (int cyc = 0; cyc < timeout_cycles && !seen; cyc++) begin
      @(negedge clk);
      if (dmem_we && dmem_addr == marker_addr) seen = 1'b1;
    end
    if (!seen) begin
      $display("%s: no store to the marker address within %0d cycles", test_name,
               timeout_cycles);
      test_errs++;
    end
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_word(input logic [31:0] addr, input logic [31:0] exp);
    check_value($sformatf("word %h", addr), exp, dmem[addr[9:2]]);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, test_errs);
    end
  endtask

  // ====================
  // directed tests
  // ====================
  task automatic reset_behavior();
    begin_test("reset");
    start_program();
    put(store_word(5'd0, marker_addr[11:0]));
    put(enc_j(21'd0, 5'd0));
    release_reset();
    check_value("imem_addr_o", 32'd0, imem_addr);
    check_value("dmem_we_o", 32'd0, {31'd0, dmem_we});
    // first store reaches the memory stage in its fourth cycle
    for (int cyc = 1; cyc <= 3; cyc++) begin
      @(negedge clk);
      check_value($sformatf("dmem_we_o in cycle %0d", cyc + 1), {31'd0, cyc == 3},
                  {31'd0, dmem_we});
    end
    end_test();
  endtask

  task automatic alu_operations();
    logic [31:0] a, b, imm_x;
    logic [11:0] imm;
    begin_test("alu_ops");
    for (int round = 0; round < 3; round++) begin
      a = $urandom;
      b = $urandom;
      imm = 12'($urandom);
      imm_x = {{20{imm[11]}}, imm};
      start_program();
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int k = 0; k < 8; k++) begin
        put(enc_r((k == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3_table[k], 5'd3));
        put(store_word(5'd3, 12'(256 + 4 * k)));
      end
      for (int k = 0; k < 5; k++) begin
        put(enc_i(imm, 5'd1, f3_table[i_ops[k]], 5'd4, op_i));
        put(store_word(5'd4, 12'(320 + 4 * k)));
      end
      run_program();
      for (int k = 0; k < 8; k++) check_word(32'(256 + 4 * k), alu_ref(k, a, b));
      for (int k = 0; k < 5; k++) check_word(32'(320 + 4 * k), alu_ref(i_ops[k], a, imm_x));
    end
    end_test();
  endtask

  task automatic dependent_chain();
    logic [31:0] a, b, e3, e4, e5, e6, e7;
    begin_test("forwarding");
    a = $urandom;
    b = $urandom;
    e3 = a + b;
    e4 = e3 - a;
    e5 = e3 ^ e4;
    e6 = e3 | e5;
    e7 = e4 & e6;
    start_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    put(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    put(enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd5));
    put(enc_r(7'h00, 5'd5, 5'd3, 3'b110, 5'd6));
    put(enc_r(7'h00, 5'd6, 5'd4, 3'b111, 5'd7));
    put(store_word(5'd7, 12'h180));
    // write to x0 right before a read of x0
    put(enc_i(12'd5, 5'd0, 3'b000, 5'd0, op_i));
    put(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd8));
    for (int k = 0; k < 4; k++) put(store_word(5'(3 + k), 12'(388 + 4 * k)));
    put(store_word(5'd8, 12'h194));
    run_program();
    check_word(32'h180, e7);
    check_word(32'h184, e3);
    check_word(32'h188, e4);
    check_word(32'h18c, e5);
    check_word(32'h190, e6);
    check_word(32'h194, a);
    end_test();
  endtask

  task automatic load_use_stall();
    logic [31:0] a, b;
    begin_test("load_use");
    a = $urandom;
    b = $urandom;
    start_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    put(store_word(5'd1, 12'h200));
    put(load_word(5'd3, 12'h200));
    put(enc_r(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
    put(store_word(5'd4, 12'h204));
    put(load_word(5'd5, 12'h200));
    put(enc_r(7'h20, 5'd5, 5'd2, 3'b000, 5'd6));
    put(store_word(5'd6, 12'h208));
    put(load_word(5'd7, 12'h200));
    put(store_word(5'd7, 12'h20c));
    run_program();
    check_word(32'h200, a);
    check_word(32'h204, a + b);
    check_word(32'h208, b - a);
    check_word(32'h20c, a);
    end_test();
  endtask

  task automatic branch_and_jump();
    logic [31:0] a, jal_pc;
    begin_test("branches");
    a = $urandom;
    start_program();
    load_const(5'd1, a);
    put(enc_i(12'd0, 5'd1, 3'b000, 5'd2, op_i));
    put(enc_i(12'd1, 5'd1, 3'b000, 5'd3, op_i));
    // taken beq and bne with three stores in each shadow
    put(enc_b(13'd16, 5'd2, 5'd1, 3'b000));
    for (int k = 0; k < 3; k++) put(store_word(5'd1, 12'(768 + 4 * k)));
    put(enc_b(13'd16, 5'd3, 5'd1, 3'b001));
    for (int k = 0; k < 3; k++) put(store_word(5'd1, 12'(780 + 4 * k)));
    // not taken so the fall-through runs
    put(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
    put(store_word(5'd1, 12'h318));
    put(enc_b(13'd8, 5'd3, 5'd1, 3'b000));
    put(store_word(5'd3, 12'h31c));
    jal_pc = 32'(prog_len) << 2;
    put(enc_j(21'd16, 5'd5));
    for (int k = 0; k < 3; k++) put(store_word(5'd1, 12'(800 + 4 * k)));
    put(store_word(5'd5, 12'h32c));
    run_program();
    for (int k = 0; k < 6; k++) check_word(32'(768 + 4 * k), fill_of(32'(768 + 4 * k)));
    for (int k = 0; k < 3; k++) check_word(32'(800 + 4 * k), fill_of(32'(800 + 4 * k)));
    check_word(32'h318, a);
    check_word(32'h31c, a + 32'd1);
    check_word(32'h32c, jal_pc + 32'd4);
    end_test();
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    arst_n = 1'b0;
    void'($urandom(66806));
    tests_run = 0;
    tests_failed = 0;
    total_errs = 0;
    reset_behavior();
    alu_operations();
    dependent_chain();
    load_use_stall();
    branch_and_jump();
    $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
             total_errs);
    if (total_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic          clk,
  input  logic          arst_n_i,
  output rv_pkg::word_t imem_addr_o,
  input  rv_pkg::word_t imem_data_i,
  output rv_pkg::word_t dmem_addr_o,
  output rv_pkg::word_t dmem_wdata_o,
  output logic          dmem_we_o,
  input  rv_pkg::word_t dmem_rdata_i
);

  // fetch / decode
  rv_pkg::word_t pc_id, instr_id;
  rv_pkg::opcode_t opcode;
  logic [2:0] fun3;
  logic fun7_5;
  rv_pkg::reg_addr_t rs1, rs2;
  // decoded control
  logic reg_write, mem_write, mem_read, alu_src, branch, branch_ne, jump;
  logic [1:0] result_sel;
  rv_pkg::alu_ctrl_t alu_ctrl;
  // pipeline control
  logic pc_en, ifid_en, ifid_clr, idex_clr, exmem_clr;
  logic [1:0] fwd_a, fwd_b;
  // id/ex bundle
  rv_pkg::word_t pc_ex, rdata1_ex, rdata2_ex, imm_ex;
  rv_pkg::reg_addr_t rs1_ex, rs2_ex, rd_ex;
  logic reg_write_ex, mem_write_ex, mem_read_ex, alu_src_ex, branch_ex, branch_ne_ex, jump_ex;
  logic [1:0] result_sel_ex;
  rv_pkg::alu_ctrl_t alu_ctrl_ex;
  // execute feedback
  rv_pkg::reg_addr_t rd_exe, rs1_exe, rs2_exe;
  logic mem_read_exe;
  // ex/mem bundle
  rv_pkg::word_t pc_mem, alu_mem, store_mem, imm_mem, target_mem;
  rv_pkg::reg_addr_t rd_mem_q;
  logic reg_write_mem_q, mem_write_mem, mem_read_mem, branch_mem, branch_ne_mem, jump_mem;
  logic zero_mem;
  logic [1:0] result_sel_mem;
  // memory stage outputs
  rv_pkg::word_t result_mem, target, wdata_wb;
  rv_pkg::reg_addr_t rd_mem, rd_wb;
  logic reg_write_mem, reg_write_wb, take_mem;

  pipe_control pipe_control_i (.*, .opcode_i(opcode), .fun3_i(fun3), .fun7_5_i(fun7_5),
    .rs1_i(rs1), .rs2_i(rs2), .rs1_exe_i(rs1_exe), .rs2_exe_i(rs2_exe), .rd_exe_i(rd_exe),
    .mem_read_exe_i(mem_read_exe), .rd_mem_i(rd_mem), .reg_write_mem_i(reg_write_mem),
    .rd_wb_i(rd_wb), .reg_write_wb_i(reg_write_wb), .take_mem_i(take_mem),
    .reg_write_o(reg_write), .mem_write_o(mem_write), .mem_read_o(mem_read),
    .result_sel_o(result_sel), .alu_src_o(alu_src), .branch_o(branch),
    .branch_ne_o(branch_ne), .jump_o(jump), .alu_ctrl_o(alu_ctrl), .fwd_a_o(fwd_a),
    .fwd_b_o(fwd_b), .pc_en_o(pc_en), .ifid_en_o(ifid_en), .ifid_clr_o(ifid_clr),
    .idex_clr_o(idex_clr), .exmem_clr_o(exmem_clr));

  fetch_stage fetch_stage_i (.clk(clk), .arst_n_i(arst_n_i), .pc_en_i(pc_en),
    .ifid_en_i(ifid_en), .ifid_clr_i(ifid_clr), .take_i(take_mem), .target_i(target),
    .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i), .pc_id_o(pc_id),
    .instr_id_o(instr_id));

  decode_stage decode_stage_i (.clk(clk), .arst_n_i(arst_n_i), .instr_i(instr_id),
    .pc_i(pc_id), .reg_write_i(reg_write), .mem_write_i(mem_write), .mem_read_i(mem_read),
    .result_sel_i(result_sel), .alu_src_i(alu_src), .branch_i(branch),
    .branch_ne_i(branch_ne), .jump_i(jump), .alu_ctrl_i(alu_ctrl), .idex_clr_i(idex_clr),
    .rd_wb_i(rd_wb), .reg_write_wb_i(reg_write_wb), .wdata_wb_i(wdata_wb),
    .opcode_o(opcode), .fun3_o(fun3), .fun7_5_o(fun7_5), .rs1_o(rs1), .rs2_o(rs2),
    .pc_ex_o(pc_ex), .rdata1_ex_o(rdata1_ex), .rdata2_ex_o(rdata2_ex), .imm_ex_o(imm_ex),
    .rs1_ex_o(rs1_ex), .rs2_ex_o(rs2_ex), .rd_ex_o(rd_ex), .reg_write_ex_o(reg_write_ex),
    .mem_write_ex_o(mem_write_ex), .mem_read_ex_o(mem_read_ex),
    .result_sel_ex_o(result_sel_ex), .alu_src_ex_o(alu_src_ex), .branch_ex_o(branch_ex),
    .branch_ne_ex_o(branch_ne_ex), .jump_ex_o(jump_ex), .alu_ctrl_ex_o(alu_ctrl_ex));

  execute_stage execute_stage_i (.clk(clk), .arst_n_i(arst_n_i), .pc_i(pc_ex),
    .rdata1_i(rdata1_ex), .rdata2_i(rdata2_ex), .imm_i(imm_ex), .rs1_i(rs1_ex),
    .rs2_i(rs2_ex), .rd_i(rd_ex), .reg_write_i(reg_write_ex), .mem_write_i(mem_write_ex),
    .mem_read_i(mem_read_ex), .result_sel_i(result_sel_ex), .alu_src_i(alu_src_ex),
    .branch_i(branch_ex), .branch_ne_i(branch_ne_ex), .jump_i(jump_ex),
    .alu_ctrl_i(alu_ctrl_ex), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .result_mem_i(result_mem),
    .wdata_wb_i(wdata_wb), .exmem_clr_i(exmem_clr), .rd_exe_o(rd_exe),
    .mem_read_exe_o(mem_read_exe), .rs1_exe_o(rs1_exe), .rs2_exe_o(rs2_exe),
    .pc_mem_o(pc_mem), .alu_mem_o(alu_mem), .store_mem_o(store_mem), .imm_mem_o(imm_mem),
    .target_mem_o(target_mem), .rd_mem_o(rd_mem_q), .reg_write_mem_o(reg_write_mem_q),
    .mem_write_mem_o(mem_write_mem), .mem_read_mem_o(mem_read_mem),
    .result_sel_mem_o(result_sel_mem), .branch_mem_o(branch_mem),
    .branch_ne_mem_o(branch_ne_mem), .jump_mem_o(jump_mem), .zero_mem_o(zero_mem));

  memory_stage memory_stage_i (.clk(clk), .arst_n_i(arst_n_i), .pc_i(pc_mem),
    .alu_i(alu_mem), .store_i(store_mem), .imm_i(imm_mem), .target_i(target_mem),
    .rd_i(rd_mem_q), .reg_write_i(reg_write_mem_q), .mem_write_i(mem_write_mem),
    .mem_read_i(mem_read_mem), .result_sel_i(result_sel_mem), .branch_i(branch_mem),
    .branch_ne_i(branch_ne_mem), .jump_i(jump_mem), .zero_i(zero_mem),
    .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o),
    .dmem_rdata_i(dmem_rdata_i), .result_mem_o(result_mem), .take_mem_o(take_mem),
    .target_o(target), .rd_mem_o(rd_mem), .reg_write_mem_o(reg_write_mem),
    .rd_wb_o(rd_wb), .reg_write_wb_o(reg_write_wb), .wdata_wb_o(wdata_wb));

endmodule

/* hdl/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  input  rv_pkg::word_t     pc_i,
  input  rv_pkg::word_t     alu_i,
  input  rv_pkg::word_t     store_i,
  input  rv_pkg::word_t     imm_i,
  input  rv_pkg::word_t     target_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              reg_write_i,
  input  logic              mem_write_i,
  input  logic              mem_read_i,
  input  logic [1:0]        result_sel_i,
  input  logic              branch_i,
  input  logic              branch_ne_i,
  input  logic              jump_i,
  input  logic              zero_i,
  output rv_pkg::word_t     dmem_addr_o,
  output rv_pkg::word_t     dmem_wdata_o,
  output logic              dmem_we_o,
  input  rv_pkg::word_t     dmem_rdata_i,
  output rv_pkg::word_t     result_mem_o,
  output logic              take_mem_o,
  output rv_pkg::word_t     target_o,
  output rv_pkg::reg_addr_t rd_mem_o,
  output logic              reg_write_mem_o,
  output rv_pkg::reg_addr_t rd_wb_o,
  output logic              reg_write_wb_o,
  output rv_pkg::word_t     wdata_wb_o
);

  rv_pkg::word_t result_wb;
  logic mem_read_wb;

  assign take_mem_o      = jump_i || (branch_i && (zero_i ^ branch_ne_i));
  assign target_o        = target_i;
  assign rd_mem_o        = rd_i;
  assign reg_write_mem_o = reg_write_i;

  assign result_mem_o = (result_sel_i == rv_pkg::res_pc4) ? pc_i + 32'd4 :
                        (result_sel_i == rv_pkg::res_imm) ? imm_i : alu_i;

  assign dmem_addr_o  = alu_i;
  assign dmem_wdata_o = store_i;
  assign dmem_we_o    = mem_write_i;

  // mem/wb register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_write_wb_o <= 1'b0;
      mem_read_wb    <= 1'b0;
    end else begin
      reg_write_wb_o <= reg_write_i;
      mem_read_wb    <= mem_read_i;
    end
  end

  always_ff @(posedge clk) begin
    rd_wb_o   <= rd_i;
    result_wb <= result_mem_o;
  end

  // load data arrives here from the synchronous read
  assign wdata_wb_o = mem_read_wb ? dmem_rdata_i : result_wb;

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  input  rv_pkg::word_t     pc_i,
  input  rv_pkg::word_t     rdata1_i,
  input  rv_pkg::word_t     rdata2_i,
  input  rv_pkg::word_t     imm_i,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              reg_write_i,
  input  logic              mem_write_i,
  input  logic              mem_read_i,
  input  logic [1:0]        result_sel_i,
  input  logic              alu_src_i,
  input  logic              branch_i,
  input  logic              branch_ne_i,
  input  logic              jump_i,
  input  rv_pkg::alu_ctrl_t alu_ctrl_i,
  input  logic [1:0]        fwd_a_i,
  input  logic [1:0]        fwd_b_i,
  input  rv_pkg::word_t     result_mem_i,
  input  rv_pkg::word_t     wdata_wb_i,
  input  logic              exmem_clr_i,
  output rv_pkg::reg_addr_t rd_exe_o,
  output logic              mem_read_exe_o,
  output rv_pkg::reg_addr_t rs1_exe_o,
  output rv_pkg::reg_addr_t rs2_exe_o,
  output rv_pkg::word_t     pc_mem_o,
  output rv_pkg::word_t     alu_mem_o,
  output rv_pkg::word_t     store_mem_o,
  output rv_pkg::word_t     imm_mem_o,
  output rv_pkg::word_t     target_mem_o,
  output rv_pkg::reg_addr_t rd_mem_o,
  output logic              reg_write_mem_o,
  output logic              mem_write_mem_o,
  output logic              mem_read_mem_o,
  output logic [1:0]        result_sel_mem_o,
  output logic              branch_mem_o,
  output logic              branch_ne_mem_o,
  output logic              jump_mem_o,
  output logic              zero_mem_o
);

  rv_pkg::word_t op_a, fwd_b, op_b, alu_res;

  assign rd_exe_o       = rd_i;
  assign mem_read_exe_o = mem_read_i;
  assign rs1_exe_o      = rs1_i;
  assign rs2_exe_o      = rs2_i;

  // forwarding muxes
  assign op_a  = (fwd_a_i == 2'd1) ? result_mem_i : (fwd_a_i == 2'd2) ? wdata_wb_i : rdata1_i;
  assign fwd_b = (fwd_b_i == 2'd1) ? result_mem_i : (fwd_b_i == 2'd2) ? wdata_wb_i : rdata2_i;
  assign op_b  = alu_src_i ? imm_i : fwd_b;

  always_comb begin
    case (alu_ctrl_i)
      rv_pkg::alu_sub:    alu_res = op_a - op_b;
      rv_pkg::alu_and:    alu_res = op_a & op_b;
      rv_pkg::alu_or:     alu_res = op_a | op_b;
      rv_pkg::alu_xor:    alu_res = op_a ^ op_b;
      rv_pkg::alu_slt:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sll:    alu_res = op_a << op_b[4:0];
      rv_pkg::alu_srl:    alu_res = op_a >> op_b[4:0];
      rv_pkg::alu_pass_b: alu_res = op_b;
      default:            alu_res = op_a + op_b;
    endcase
  end

  // ====================
  // ex/mem register
  // ====================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i || exmem_clr_i) begin
      {reg_write_mem_o, mem_write_mem_o, mem_read_mem_o, branch_mem_o, jump_mem_o} <= '0;
    end else begin
      {reg_write_mem_o, mem_write_mem_o, mem_read_mem_o, branch_mem_o, jump_mem_o} <=
        {reg_write_i, mem_write_i, mem_read_i, branch_i, jump_i};
    end
  end

  always_ff @(posedge clk) begin
    pc_mem_o         <= pc_i;
    alu_mem_o        <= alu_res;
    store_mem_o      <= fwd_b;
    imm_mem_o        <= imm_i;
    target_mem_o     <= pc_i + imm_i;
    rd_mem_o         <= rd_i;
    result_sel_mem_o <= result_sel_i;
    branch_ne_mem_o  <= branch_ne_i;
    // zero only means something for sub
    zero_mem_o       <= (alu_res == '0);
  end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  input  rv_pkg::word_t     instr_i,
  input  rv_pkg::word_t     pc_i,
  input  logic              reg_write_i,
  input  logic              mem_write_i,
  input  logic              mem_read_i,
  input  logic [1:0]        result_sel_i,
  input  logic              alu_src_i,
  input  logic              branch_i,
  input  logic              branch_ne_i,
  input  logic              jump_i,
  input  rv_pkg::alu_ctrl_t alu_ctrl_i,
  input  logic              idex_clr_i,
  input  rv_pkg::reg_addr_t rd_wb_i,
  input  logic              reg_write_wb_i,
  input  rv_pkg::word_t     wdata_wb_i,
  output rv_pkg::opcode_t   opcode_o,
  output logic [2:0]        fun3_o,
  output logic              fun7_5_o,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::word_t     pc_ex_o,
  output rv_pkg::word_t     rdata1_ex_o,
  output rv_pkg::word_t     rdata2_ex_o,
  output rv_pkg::word_t     imm_ex_o,
  output rv_pkg::reg_addr_t rs1_ex_o,
  output rv_pkg::reg_addr_t rs2_ex_o,
  output rv_pkg::reg_addr_t rd_ex_o,
  output logic              reg_write_ex_o,
  output logic              mem_write_ex_o,
  output logic              mem_read_ex_o,
  output logic [1:0]        result_sel_ex_o,
  output logic              alu_src_ex_o,
  output logic              branch_ex_o,
  output logic              branch_ne_ex_o,
  output logic              jump_ex_o,
  output rv_pkg::alu_ctrl_t alu_ctrl_ex_o
);

  rv_pkg::word_t regs [32];
  rv_pkg::word_t rdata1, rdata2, imm;
  logic wb_hit;

  assign opcode_o = instr_i[6:0];
  assign fun3_o   = instr_i[14:12];
  assign fun7_5_o = instr_i[30];
  assign rs1_o    = instr_i[19:15];
  assign rs2_o    = instr_i[24:20];

  // register file, x0 never written
  always_ff @(posedge clk) begin
    if (reg_write_wb_i && rd_wb_i != '0) regs[rd_wb_i] <= wdata_wb_i;
  end

  // write-back bypass around the array
  assign wb_hit = reg_write_wb_i && rd_wb_i != '0;
  assign rdata1 = (rs1_o == '0) ? '0 : (wb_hit && rd_wb_i == rs1_o) ? wdata_wb_i : regs[rs1_o];
  assign rdata2 = (rs2_o == '0) ? '0 : (wb_hit && rd_wb_i == rs2_o) ? wdata_wb_i : regs[rs2_o];

  // immediate by format
  always_comb begin
    case (opcode_o)
      rv_pkg::op_store:  imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      rv_pkg::op_branch: imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
      rv_pkg::op_lui:    imm = {instr_i[31:12], 12'd0};
      rv_pkg::op_jal:    imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                instr_i[20], instr_i[30:21], 1'b0};
      default:           imm = {{20{instr_i[31]}}, instr_i[31:20]};
    endcase
  end

  // ====================
  // id/ex register
  // ====================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      {reg_write_ex_o, mem_write_ex_o, mem_read_ex_o, branch_ex_o, jump_ex_o} <= '0;
    end else if (idex_clr_i) begin
      {reg_write_ex_o, mem_write_ex_o, mem_read_ex_o, branch_ex_o, jump_ex_o} <= '0;
    end else begin
      {reg_write_ex_o, mem_write_ex_o, mem_read_ex_o, branch_ex_o, jump_ex_o} <=
        {reg_write_i, mem_write_i, mem_read_i, branch_i, jump_i};
    end
  end

  always_ff @(posedge clk) begin
    pc_ex_o         <= pc_i;
    rdata1_ex_o     <= rdata1;
    rdata2_ex_o     <= rdata2;
    imm_ex_o        <= imm;
    rs1_ex_o        <= rs1_o;
    rs2_ex_o        <= rs2_o;
    rd_ex_o         <= instr_i[11:7];
    result_sel_ex_o <= result_sel_i;
    alu_src_ex_o    <= alu_src_i;
    branch_ne_ex_o  <= branch_ne_i;
    alu_ctrl_ex_o   <= alu_ctrl_i;
  end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic          clk,
  input  logic          arst_n_i,
  input  logic          pc_en_i,
  input  logic          ifid_en_i,
  input  logic          ifid_clr_i,
  input  logic          take_i,
  input  rv_pkg::word_t target_i,
  output rv_pkg::word_t imem_addr_o,
  input  rv_pkg::word_t imem_data_i,
  output rv_pkg::word_t pc_id_o,
  output rv_pkg::word_t instr_id_o
);

  rv_pkg::word_t pc_q, pc_next;

  assign pc_next     = take_i ? target_i : pc_q + 32'd4;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= rv_pkg::reset_pc;
    end else if (pc_en_i) begin
      pc_q <= pc_next;
    end
  end

  // if/id register, clear gives a nop
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_id_o <= rv_pkg::nop_instr;
    end else if (ifid_clr_i) begin
      instr_id_o <= rv_pkg::nop_instr;
    end else if (ifid_en_i) begin
      instr_id_o <= imem_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ifid_en_i) pc_id_o <= pc_q;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i) pc_q[1:0] == 2'b00);

endmodule

/* hdl/pipe_control.sv */
`timescale 1ns/1ps

module pipe_control (
  input  logic              clk,
  input  logic              arst_n_i,
  input  rv_pkg::opcode_t   opcode_i,
  input  logic [2:0]        fun3_i,
  input  logic              fun7_5_i,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  input  rv_pkg::reg_addr_t rs1_exe_i,
  input  rv_pkg::reg_addr_t rs2_exe_i,
  input  rv_pkg::reg_addr_t rd_exe_i,
  input  logic              mem_read_exe_i,
  input  rv_pkg::reg_addr_t rd_mem_i,
  input  logic              reg_write_mem_i,
  input  rv_pkg::reg_addr_t rd_wb_i,
  input  logic              reg_write_wb_i,
  input  logic              take_mem_i,
  output logic              reg_write_o,
  output logic              mem_write_o,
  output logic              mem_read_o,
  output logic [1:0]        result_sel_o,
  output logic              alu_src_o,
  output logic              branch_o,
  output logic              branch_ne_o,
  output logic              jump_o,
  output rv_pkg::alu_ctrl_t alu_ctrl_o,
  output logic [1:0]        fwd_a_o,
  output logic [1:0]        fwd_b_o,
  output logic              pc_en_o,
  output logic              ifid_en_o,
  output logic              ifid_clr_o,
  output logic              idex_clr_o,
  output logic              exmem_clr_o
);

  logic stall;
  rv_pkg::alu_ctrl_t alu_fun;

  // ====================
  // decoder
  // ====================
  always_comb begin
    case (fun3_i)
      3'b000:  alu_fun = (opcode_i == rv_pkg::op_rtype && fun7_5_i) ? rv_pkg::alu_sub
                                                                      : rv_pkg::alu_add;
      3'b111:  alu_fun = rv_pkg::alu_and;
      3'b110:  alu_fun = rv_pkg::alu_or;
      3'b100:  alu_fun = rv_pkg::alu_xor;
      3'b010:  alu_fun = rv_pkg::alu_slt;
      3'b001:  alu_fun = rv_pkg::alu_sll;
      default: alu_fun = rv_pkg::alu_srl;
    endcase
  end

  always_comb begin
    reg_write_o  = 1'b0;
    mem_write_o  = 1'b0;
    mem_read_o   = 1'b0;
    result_sel_o = rv_pkg::res_alu;
    alu_src_o    = 1'b0;
    branch_o     = 1'b0;
    branch_ne_o  = 1'b0;
    jump_o       = 1'b0;
    alu_ctrl_o   = rv_pkg::alu_add;
    case (opcode_i)
      rv_pkg::op_rtype: begin
        reg_write_o = 1'b1;
        alu_ctrl_o  = alu_fun;
      end
      rv_pkg::op_itype: begin
        reg_write_o = 1'b1;
        alu_src_o   = 1'b1;
        alu_ctrl_o  = alu_fun;
      end
      rv_pkg::op_lui: begin
        reg_write_o  = 1'b1;
        alu_src_o    = 1'b1;
        alu_ctrl_o   = rv_pkg::alu_pass_b;
        result_sel_o = rv_pkg::res_imm;
      end
      rv_pkg::op_load: begin
        reg_write_o = 1'b1;
        mem_read_o  = 1'b1;
        alu_src_o   = 1'b1;
      end
      rv_pkg::op_store: begin
        mem_write_o = 1'b1;
        alu_src_o   = 1'b1;
      end
      rv_pkg::op_branch: begin
        branch_o    = 1'b1;
        branch_ne_o = fun3_i[0];
        alu_ctrl_o  = rv_pkg::alu_sub;
      end
      rv_pkg::op_jal: begin
        reg_write_o  = 1'b1;
        jump_o       = 1'b1;
        result_sel_o = rv_pkg::res_pc4;
      end
      default: ;
    endcase
  end

  // ====================
  // forwarding with mem stage priority
  // ====================
  always_comb begin
    fwd_a_o = 2'd0;
    fwd_b_o = 2'd0;
    if (reg_write_mem_i && rd_mem_i != '0 && rd_mem_i == rs1_exe_i) fwd_a_o = 2'd1;
    else if (reg_write_wb_i && rd_wb_i != '0 && rd_wb_i == rs1_exe_i) fwd_a_o = 2'd2;
    if (reg_write_mem_i && rd_mem_i != '0 && rd_mem_i == rs2_exe_i) fwd_b_o = 2'd1;
    else if (reg_write_wb_i && rd_wb_i != '0 && rd_wb_i == rs2_exe_i) fwd_b_o = 2'd2;
  end

  // load-use stall gives way to a flush
  assign stall       = mem_read_exe_i && rd_exe_i != '0 &&
                       (rd_exe_i == rs1_i || rd_exe_i == rs2_i);
  assign pc_en_o     = !stall || take_mem_i;
  assign ifid_en_o   = !stall || take_mem_i;
  assign ifid_clr_o  = take_mem_i;
  assign idex_clr_o  = stall || take_mem_i;
  assign exmem_clr_o = take_mem_i;

  // a stall leaves a bubble behind the load, so it cannot repeat
  a_single_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    stall && !take_mem_i |=> !stall);
  // a flush empties execute so no stall follows it
  a_flush_no_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    take_mem_i |=> !stall);

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

  // ====================
  // widths and types
  // ====================
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      alu_ctrl_t;
  typedef logic [6:0]      opcode_t;

  // alu operations
  localparam alu_ctrl_t alu_add    = 4'd0;
  localparam alu_ctrl_t alu_sub    = 4'd1;
  localparam alu_ctrl_t alu_and    = 4'd2;
  localparam alu_ctrl_t alu_or     = 4'd3;
  localparam alu_ctrl_t alu_xor    = 4'd4;
  localparam alu_ctrl_t alu_slt    = 4'd5;
  localparam alu_ctrl_t alu_sll    = 4'd6;
  localparam alu_ctrl_t alu_srl    = 4'd7;
  localparam alu_ctrl_t alu_pass_b = 4'd8;

  // ====================
  // rv32i opcodes
  // ====================
  localparam opcode_t op_rtype  = 7'b0110011;
  localparam opcode_t op_itype  = 7'b0010011;
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_jal    = 7'b1101111;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;
  localparam word_t reset_pc  = 32'h0000_0000;

  // result select in the memory stage
  localparam logic [1:0] res_alu = 2'd0;
  localparam logic [1:0] res_pc4 = 2'd1;
  localparam logic [1:0] res_imm = 2'd2;

endpackage
